// ==== logic/tgfx16_pkg.sv ====
// Shared widths, pad, audio, backup RAM and sector channel types
package tgfx16_pkg;

	// ==========================================================================
	// Controller port
	// ==========================================================================
	localparam int PAD_COUNT = 5;

	typedef struct packed {
		logic up;
		logic down;
		logic left;
		logic right;
		logic i;
		logic ii;
		logic select;
		logic run;
		logic iii;  // Six-button extras
		logic iv;
		logic v;
		logic vi;
	} pad_buttons_t;

	typedef pad_buttons_t [PAD_COUNT-1:0] pad_bank_t;

	typedef struct packed {
		logic swap;       // Pads 0 and 1 exchanged
		logic multitap;
		logic six_button;
	} pad_opts_t;

	typedef struct packed {
		logic sel;
		logic clr;
	} pad_bus_t;

	// ==========================================================================
	// Audio
	// ==========================================================================
	localparam int AUDIO_W = 22;  // Accumulator
	localparam int DAC_W   = 19;

	typedef struct packed {
		logic signed [19:0] psg_l;
		logic signed [19:0] psg_r;
		logic signed [19:0] cdda_l;
		logic signed [19:0] cdda_r;
		logic signed [15:0] adpcm;  // Mono, fed to both sides
	} audio_src_t;

	typedef struct packed {
		logic [DAC_W-1:0] left;
		logic [DAC_W-1:0] right;
	} audio_out_t;

	// ==========================================================================
	// Backup RAM and sector channel
	// ==========================================================================
	localparam int BRM_AW    = 11;
	localparam int SECTOR_AW = 9;

	typedef struct packed {
		logic [BRM_AW-1:0] addr;
		logic              we;
		logic [7:0]        din;
	} brm_port_t;

	typedef struct packed {
		logic       rd;
		logic       wr;
		logic [1:0] lba;  // Sector 0 to 3 of the image
	} sector_req_t;

	typedef enum logic {
		DIR_LOAD,
		DIR_SAVE
	} sector_dir_e;

	typedef enum logic [1:0] {
		BK_IDLE,
		BK_WAIT_ACK,
		BK_XFER
	} bk_state_e;

endpackage

// ==== logic/pad_port.sv ====
// Pad port: swap, multitap port counter, six-button page and nibble register
`timescale 1ns/10ps

module pad_port import tgfx16_pkg::*; (
	input  logic       clk_sys,
	input  logic       rst_n,
	input  pad_bus_t   pad_bus,
	input  pad_bank_t  pads,
	input  pad_opts_t  opts,
	output logic [3:0] pad_nibble
);

	pad_bank_t   eff_pads;    // Pads after the swap
	logic [15:0] pad_word;    // Four active-low groups of the selected port
	logic [3:0]  sel_nibble;
	logic [2:0]  port_cnt;
	pad_bus_t    bus_d;       // Last console lines
	logic        page;        // Six-button page

	// Group 3 stays zero, which the console reads as six-button signature
	function automatic logic [15:0] encode_pad(pad_buttons_t b);
		return ~{4'hF,
			b.vi, b.v, b.iv, b.iii,
			b.left, b.down, b.right, b.up,
			b.run, b.select, b.ii, b.i};
	endfunction

	always_comb begin
		eff_pads = pads;
		if (opts.swap) begin
			eff_pads[0] = pads[1];
			eff_pads[1] = pads[0];
		end
	end

	// Ports past the last pad read as nothing pressed
	always_comb begin
		case (port_cnt)
			3'd0: pad_word = encode_pad(eff_pads[0]);
			3'd1: pad_word = encode_pad(eff_pads[1]);
			3'd2: pad_word = encode_pad(eff_pads[2]);
			3'd3: pad_word = encode_pad(eff_pads[3]);
			3'd4: pad_word = encode_pad(eff_pads[4]);
			default: pad_word = 16'h0FFF;
		endcase
	end

	assign sel_nibble = pad_word[{page, pad_bus.sel, 2'b00} +: 4];

	// ==========================================================================
	// Port counter, page and output register
	// ==========================================================================
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			pad_nibble <= '0;
			port_cnt   <= '0;
			bus_d      <= '0;
			page       <= 1'b0;
		end else begin
			bus_d <= pad_bus;

			if (pad_bus.clr) begin
				pad_nibble <= '0;
				port_cnt   <= '0;
			end else begin
				pad_nibble <= sel_nibble;
				if (opts.multitap && pad_bus.sel && !bus_d.sel)
					port_cnt <= port_cnt + 3'd1;  // Next tap port
			end

			// Page flips on each clr rise in six-button mode
			if (!opts.six_button)
				page <= 1'b0;
			else if (pad_bus.clr && !bus_d.clr)
				page <= ~page;
		end
	end

	// Without the tap the console only ever sees pad 0
	a_port_range: assert property (@(posedge clk_sys) disable iff (!rst_n)
		!opts.multitap |-> port_cnt <= 3'(PAD_COUNT))
		else $error("pad_port: port counter past %0d without multitap", PAD_COUNT);

endmodule

// ==== logic/audio_mix.sv ====
// Stereo audio mixer: PSG, CD-DA and ADPCM sum, clamp and unsigned DAC word
`timescale 1ns/10ps

module audio_mix import tgfx16_pkg::*; #(
	parameter int AUDIO_W = tgfx16_pkg::AUDIO_W
) (
	input  logic       clk_sys,
	input  logic       rst_n,
	input  audio_src_t src,
	input  logic       audio_valid,
	output audio_out_t out,
	output logic       out_valid
);

	logic signed [AUDIO_W-1:0] psg_l_x;
	logic signed [AUDIO_W-1:0] psg_r_x;
	logic signed [AUDIO_W-1:0] cdda_l_x;
	logic signed [AUDIO_W-1:0] cdda_r_x;
	logic signed [AUDIO_W-1:0] adpcm_x;
	logic signed [AUDIO_W-1:0] acc_l;
	logic signed [AUDIO_W-1:0] acc_r;

	// Clamp to DAC_W bits, then flip the sign to get offset binary
	function automatic logic [DAC_W-1:0] to_dac(logic signed [AUDIO_W-1:0] acc);
		logic             sign;
		logic [DAC_W-2:0] mag;
		sign = acc[AUDIO_W-1];
		if (acc[AUDIO_W-1:DAC_W-1] == {(AUDIO_W-DAC_W+1){sign}})
			mag = acc[DAC_W-2:0];
		else
			mag = {(DAC_W-1){~sign}};  // Full scale of the sign
		return {~sign, mag};
	endfunction

	// ==========================================================================
	// Source alignment
	// ==========================================================================
	assign psg_l_x  = AUDIO_W'(src.psg_l);
	assign psg_r_x  = AUDIO_W'(src.psg_r);
	assign cdda_l_x = AUDIO_W'(src.cdda_l);
	assign cdda_r_x = AUDIO_W'(src.cdda_r);
	assign adpcm_x  = {{(AUDIO_W-20){src.adpcm[15]}}, src.adpcm, 4'b0000};  // x16

	// ==========================================================================
	// Sum stage
	// ==========================================================================
	always_ff @(posedge clk_sys) begin
		if (audio_valid) begin
			acc_l <= psg_l_x + cdda_l_x + adpcm_x;
			acc_r <= psg_r_x + cdda_r_x + adpcm_x;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (!rst_n)
			out_valid <= 1'b0;
		else
			out_valid <= audio_valid;  // One cycle behind the sources
	end

	assign out.left  = to_dac(acc_l);
	assign out.right = to_dac(acc_r);

endmodule

// ==== logic/backup_ram.sv ====
// True dual-port byte RAM for the 2 KB battery backup
`timescale 1ns/10ps

module backup_ram import tgfx16_pkg::*; #(
	parameter int addr_w = BRM_AW
) (
	input  logic              clk_sys,
	input  brm_port_t         a_port,
	input  logic [addr_w-1:0] b_addr,
	input  logic              b_we,
	input  logic [7:0]        b_din,
	output logic [7:0]        a_dout,
	output logic [7:0]        b_dout
);

	localparam int DEPTH = 1 << addr_w;

	logic [7:0] mem [0:DEPTH-1];

	// ==========================================================================
	// Port A, console side
	// ==========================================================================
	always @(posedge clk_sys) begin
		if (a_port.we)
			mem[a_port.addr] <= a_port.din;
		a_dout <= mem[a_port.addr];  // Old data on a same-address write
	end

	// ==========================================================================
	// Port B, sector channel side
	// ==========================================================================
	always @(posedge clk_sys) begin
		if (b_we)
			mem[b_addr] <= b_din;
		b_dout <= mem[b_addr];
	end

endmodule

// ==== logic/backup_sync.sv ====
// Backup RAM load/save sequencer over the four-sector image channel
`timescale 1ns/10ps

module backup_sync import tgfx16_pkg::*; (
	input  logic                 clk_sys,
	input  logic                 rst_n,
	input  logic                 img_mounted,
	input  logic                 img_size_nz,
	input  logic                 bk_save,
	input  logic                 sd_ack,
	input  logic                 sd_buff_wr,
	input  logic [SECTOR_AW-1:0] sd_buff_addr,
	output sector_req_t          sd_req,
	output logic [BRM_AW-1:0]    ram_addr,
	output logic                 ram_we,
	output logic                 bk_busy,
	output logic                 console_reset
);

	bk_state_e   state;
	sector_dir_e dir;
	logic        bk_ena;     // Image mounted, saves allowed
	logic        load_pend;
	logic        save_d;
	logic        ack_d;
	logic        ack_rise;
	logic        ack_fall;
	logic        req_any;

	assign ack_rise = sd_ack & ~ack_d;
	assign ack_fall = ~sd_ack & ack_d;  // Host is done with the sector
	assign req_any  = sd_req.rd | sd_req.wr;

	assign bk_busy  = (state != BK_IDLE);
	assign ram_addr = {sd_req.lba, sd_buff_addr};
	assign ram_we   = sd_buff_wr & sd_ack;

	// ==========================================================================
	// Sequencer
	// ==========================================================================
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			state         <= BK_IDLE;
			dir           <= DIR_LOAD;
			bk_ena        <= 1'b0;
			load_pend     <= 1'b0;
			save_d        <= 1'b0;
			ack_d         <= 1'b0;
			sd_req        <= '0;
			console_reset <= 1'b0;
		end else begin
			save_d        <= bk_save;
			ack_d         <= sd_ack;
			console_reset <= 1'b0;

			case (state)
				BK_IDLE: begin
					if (bk_ena && load_pend) begin
						load_pend <= 1'b0;
						dir       <= DIR_LOAD;
						sd_req    <= '{rd: 1'b1, wr: 1'b0, lba: 2'd0};
						state     <= BK_WAIT_ACK;
					end else if (bk_ena && bk_save && !save_d) begin
						dir    <= DIR_SAVE;
						sd_req <= '{rd: 1'b0, wr: 1'b1, lba: 2'd0};
						state  <= BK_WAIT_ACK;
					end
				end
				BK_WAIT_ACK: begin
					if (ack_rise) begin
						sd_req.rd <= 1'b0;
						sd_req.wr <= 1'b0;
						state     <= BK_XFER;
					end
				end
				BK_XFER: begin
					if (ack_fall) begin
						if (&sd_req.lba) begin
							console_reset <= (dir == DIR_LOAD);  // Restart on fresh RAM
							state         <= BK_IDLE;
						end else begin
							sd_req.lba <= sd_req.lba + 2'd1;
							sd_req.rd  <= (dir == DIR_LOAD);
							sd_req.wr  <= (dir == DIR_SAVE);
							state      <= BK_WAIT_ACK;
						end
					end
				end
				default: state <= BK_IDLE;
			endcase

			// A new mount wins over a load just taken
			if (img_mounted && img_size_nz) begin
				bk_ena    <= 1'b1;
				load_pend <= 1'b1;
			end
		end
	end

	a_req_onehot: assert property (@(posedge clk_sys) disable iff (!rst_n)
		!(sd_req.rd && sd_req.wr))
		else $error("backup_sync: rd and wr both high");

	// Request and sector index hold until the host answers
	a_req_hold: assert property (@(posedge clk_sys) disable iff (!rst_n)
		req_any && !sd_ack |=> req_any && $stable(sd_req.lba))
		else $error("backup_sync: request dropped before sd_ack");

endmodule

// ==== logic/tgfx16_io_top.sv ====
// I/O block top: pad port, audio mixer, backup RAM and its sequencer
`timescale 1ns/10ps

module tgfx16_io_top import tgfx16_pkg::*; #(
	parameter int AUDIO_W = tgfx16_pkg::AUDIO_W,
	parameter int BRM_AW  = tgfx16_pkg::BRM_AW
) (
	input  logic                 clk_sys,
	input  logic                 rst_n,
	// Controllers
	input  pad_bus_t             pad_bus,
	input  pad_bank_t            pads,
	input  pad_opts_t            opts,
	output logic [3:0]           pad_nibble,
	// Audio
	input  audio_src_t           audio_src,
	input  logic                 audio_valid,
	output audio_out_t           audio_out,
	output logic                 out_valid,
	// Backup RAM, console side
	input  brm_port_t            brm_port,
	output logic [7:0]           brm_dout,
	// Sector channel
	input  logic                 sd_ack,
	input  logic [SECTOR_AW-1:0] sd_buff_addr,
	input  logic                 sd_buff_wr,
	input  logic [7:0]           sd_buff_dout,
	output sector_req_t          sd_req,
	output logic [7:0]           sd_buff_din,
	// Image and controls
	input  logic                 img_mounted,
	input  logic                 img_size_nz,
	input  logic                 bk_save,
	output logic                 bk_busy,
	output logic                 console_reset
);

	logic [BRM_AW-1:0] ram_addr;  // Sector side of the backup RAM
	logic              ram_we;

	pad_port pad_port_i (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.pad_bus    (pad_bus),
		.pads       (pads),
		.opts       (opts),
		.pad_nibble (pad_nibble)
	);

	audio_mix #(.AUDIO_W(AUDIO_W)) audio_mix_i (
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.src         (audio_src),
		.audio_valid (audio_valid),
		.out         (audio_out),
		.out_valid   (out_valid)
	);

	backup_ram #(.addr_w(BRM_AW)) backup_ram_i (
		.clk_sys (clk_sys),
		.a_port  (brm_port),
		.b_addr  (ram_addr),
		.b_we    (ram_we),
		.b_din   (sd_buff_dout),  // Host bytes on load
		.a_dout  (brm_dout),
		.b_dout  (sd_buff_din)    // Bytes to host on save
	);

	backup_sync backup_sync_i (
		.clk_sys       (clk_sys),
		.rst_n         (rst_n),
		.img_mounted   (img_mounted),
		.img_size_nz   (img_size_nz),
		.bk_save       (bk_save),
		.sd_ack        (sd_ack),
		.sd_buff_wr    (sd_buff_wr),
		.sd_buff_addr  (sd_buff_addr),
		.sd_req        (sd_req),
		.ram_addr      (ram_addr),
		.ram_we        (ram_we),
		.bk_busy       (bk_busy),
		.console_reset (console_reset)
	);

endmodule

// ==== bench/tgfx16_io_checks.svh ====
// Reference models for pad nibble and mixer output, typed compare tasks
`ifndef TGFX16_IO_CHECKS_SVH
`define TGFX16_IO_CHECKS_SVH

// Nibble index is two times the page plus sel
function automatic logic [3:0] pad_ref(input pad_bank_t p, input pad_opts_t o,
		input logic [2:0] port, input logic page, input logic sel);
	pad_buttons_t b;
	if (port >= PAD_COUNT)
		return (page && sel) ? 4'h0 : 4'hF;  // Empty tap port
	b = p[port];
	if (o.swap && port < 2)
		b = p[port ^ 3'd1];
	case ({page, sel})
		2'd0: return ~{b.run, b.select, b.ii, b.i};
		2'd1: return ~{b.left, b.down, b.right, b.up};
		2'd2: return ~{b.vi, b.v, b.iv, b.iii};
		default: return 4'h0;  // Six-button signature
	endcase
endfunction

// Linear inside +-2**18, rails outside
function automatic logic [DAC_W-1:0] dac_ref(input int v);
	if (v > 262143)
		return '1;
	if (v < -262144)
		return '0;
	return DAC_W'(v + 262144);  // Mid-scale offset
endfunction

function automatic audio_out_t mix_ref(input audio_src_t s);
	audio_out_t r;
	r.left  = dac_ref(int'(s.psg_l) + int'(s.cdda_l) + 16 * int'(s.adpcm));
	r.right = dac_ref(int'(s.psg_r) + int'(s.cdda_r) + 16 * int'(s.adpcm));
	return r;
endfunction

// ============================================================================
// Compare tasks
// ============================================================================
task automatic check_nibble(input logic [3:0] want, input logic [3:0] got);
	checks++;
	if (got !== want) begin
		errors++;
		$display("FAIL t=%0t pad_nibble exp=%h got=%h", $time, want, got);
	end
endtask

task automatic check_audio(input audio_out_t want, input audio_out_t got);
	checks++;
	if (got !== want) begin
		errors++;
		$display("FAIL t=%0t audio_out exp=%h/%h got=%h/%h", $time,
			want.left, want.right, got.left, got.right);
	end
endtask

task automatic check_byte(input string name, input logic [7:0] want, input logic [7:0] got);
	checks++;
	if (got !== want) begin
		errors++;
		$display("FAIL t=%0t %s exp=%h got=%h", $time, name, want, got);
	end
endtask

task automatic check_req(input sector_req_t want, input sector_req_t got);
	checks++;
	if (got !== want) begin
		errors++;
		$display("FAIL t=%0t sd_req exp=%h got=%h", $time, want, got);
	end
endtask

`endif

// ==== bench/tgfx16_io_tb.sv ====
// Testbench for the I/O block: pads, audio mix, backup load and save
`timescale 1ns/10ps

module tgfx16_io_tb import tgfx16_pkg::*; ();

	localparam int CLK_NS     = 40;
	localparam int AUDIO_CYC  = 200;
	localparam int IDLE_CYC   = 100;
	localparam int SECTOR_CYC = 530;  // Host delay plus 513 byte slots
	localparam int WAIT_CYC   = 20;
	localparam int RUN_CYC    = 120 + AUDIO_CYC + IDLE_CYC + 8 * SECTOR_CYC + 3 * 2048;

	logic                 clk_sys;
	logic                 rst_n;
	pad_bus_t             pad_bus;
	pad_bank_t            pads;
	pad_opts_t            opts;
	logic [3:0]           pad_nibble;
	audio_src_t           audio_src;
	logic                 audio_valid;
	audio_out_t           audio_out;
	logic                 out_valid;
	brm_port_t            brm_port;
	logic [7:0]           brm_dout;
	logic                 sd_ack;
	logic [SECTOR_AW-1:0] sd_buff_addr;
	logic                 sd_buff_wr;
	logic [7:0]           sd_buff_dout;
	sector_req_t          sd_req;
	logic [7:0]           sd_buff_din;
	logic                 img_mounted;
	logic                 img_size_nz;
	logic                 bk_save;
	logic                 bk_busy;
	logic                 console_reset;

	int         checks = 0;
	int         errors = 0;
	int         resets = 0;           // console_reset pulses seen
	int         cyc = 0;              // Rising clock edges so far
	audio_out_t audio_exp_q[$];
	int         audio_due_q[$];       // Cycle each mixer result is due in
	logic [7:0] host_img [0:2047];    // Disk image on the host side
	logic [7:0] brm_model [0:2047];
	logic [2:0] port_m = 3'd0;        // Expected tap port
	logic       page_m = 1'b0;
	pad_bus_t   bus_m = '0;

	`include "tgfx16_io_checks.svh"

	tgfx16_io_top tgfx16_io_top_i (.*);

	initial begin
		clk_sys = 1'b0;
		forever #(CLK_NS / 2) clk_sys = ~clk_sys;
	end

	always @(posedge clk_sys)
		cyc++;

	// Audio compare and reset pulse count, away from the active edge
	always @(negedge clk_sys) begin
		if (rst_n && out_valid) begin
			if (audio_exp_q.size() == 0) begin
				errors++;
				$display("ERROR t=%0t out_valid with no sample sent", $time);
			end else begin
				if (audio_due_q.pop_front() != cyc) begin
					errors++;
					$display("ERROR t=%0t audio result not one cycle after audio_valid",
						$time);
				end
				check_audio(audio_exp_q.pop_front(), audio_out);
			end
		end
		if (rst_n && console_reset)
			resets++;
	end

	initial begin
		#(RUN_CYC * 3 / 2 * CLK_NS);
		$display("ERROR t=%0t watchdog expired, run did not complete", $time);
		$display("Test failed");
		$finish;
	end

	task automatic next_cycle();
		@(posedge clk_sys);
		#2;
	endtask

	// One pad bus step, checked after the nibble register
	task automatic pad_step(input pad_bus_t bus, input pad_opts_t o, input pad_bank_t p);
		logic [3:0] want;
		next_cycle();
		pad_bus = bus;
		opts    = o;
		pads    = p;
		want = bus.clr ? 4'h0 : pad_ref(p, o, port_m, page_m, bus.sel);
		if (bus.clr)
			port_m = 3'd0;
		else if (o.multitap && bus.sel && !bus_m.sel)
			port_m = port_m + 3'd1;
		if (!o.six_button)
			page_m = 1'b0;
		else if (bus.clr && !bus_m.clr)
			page_m = ~page_m;
		bus_m = bus;
		@(posedge clk_sys);
		@(negedge clk_sys);
		check_nibble(want, pad_nibble);
	endtask

	task automatic test_pad_basic();
		pad_opts_t o;
		pad_bank_t p;
		pad_bus_t  b;
		int        k;
		o = '0;
		repeat (2) begin
			p = pad_bank_t'({$urandom, $urandom});
			b.sel = 1'b0;
			b.clr = 1'b1;
			pad_step(b, o, p);
			b.clr = 1'b0;
			for (k = 0; k < 10; k++) begin
				b.sel = k[0];
				pad_step(b, o, p);
			end
			o.swap = 1'b1;  // Second pass with pads 0 and 1 exchanged
		end
	endtask

	task automatic test_pad_tap();
		pad_opts_t o;
		pad_bank_t p;
		pad_bus_t  b;
		int        k;
		o.swap       = 1'b0;
		o.multitap   = 1'b1;
		o.six_button = 1'b1;
		p = pad_bank_t'({$urandom, $urandom});
		b.sel = 1'b0;
		b.clr = 1'b1;
		pad_step(b, o, p);
		b.clr = 1'b0;
		for (k = 0; k < 16; k++) begin  // Ports 0 to 7
			b.sel = k[0];
			pad_step(b, o, p);
		end
		for (k = 0; k < 4; k++) begin   // Page flips on every clr pulse
			b.sel = 1'b0;
			b.clr = 1'b1;
			pad_step(b, o, p);
			b.clr = 1'b0;
			pad_step(b, o, p);
			b.sel = 1'b1;
			pad_step(b, o, p);
		end
	endtask

	task automatic test_audio();
		int n;
		int sh;
		for (n = 0; n < AUDIO_CYC; n++) begin
			next_cycle();
			audio_valid = ($urandom_range(0, 3) != 0);
			if (audio_valid) begin
				sh = n[0] ? 12 : 14;  // Full scale or some headroom
				audio_src.psg_l  = 20'($signed($urandom) >>> sh);
				audio_src.psg_r  = 20'($signed($urandom) >>> sh);
				audio_src.cdda_l = 20'($signed($urandom) >>> sh);
				audio_src.cdda_r = 20'($signed($urandom) >>> sh);
				audio_src.adpcm  = 16'($signed($urandom) >>> (sh + 4));
				audio_exp_q.push_back(mix_ref(audio_src));
				audio_due_q.push_back(cyc + 1);
			end
		end
		next_cycle();
		audio_valid = 1'b0;
		repeat (2) next_cycle();
		if (audio_exp_q.size() != 0) begin
			errors++;
			$display("ERROR t=%0t %0d audio results never came out", $time, audio_exp_q.size());
		end
	endtask

	// Host side of one sector, load writes into the RAM, save reads back
	task automatic serve_sector(input logic load, input logic [1:0] lba);
		sector_req_t want;
		int          n;
		int          a;
		n = 0;
		while (!(sd_req.rd || sd_req.wr) && n < WAIT_CYC) begin
			next_cycle();
			n++;
		end
		if (n == WAIT_CYC) begin
			errors++;
			$display("ERROR t=%0t no sector request for lba %0d", $time, lba);
			return;
		end
		want.rd  = load;
		want.wr  = !load;
		want.lba = lba;
		check_req(want, sd_req);
		repeat ($urandom_range(0, 5)) next_cycle();
		sd_ack = 1'b1;
		for (a = 0; a <= 512; a++) begin
			if (!load && a > 0) begin  // Read data lags the address by one cycle
				check_byte("sd_buff_din", brm_model[{lba, 9'(a - 1)}], sd_buff_din);
				host_img[{lba, 9'(a - 1)}] = sd_buff_din;
			end
			if (a < 512) begin
				sd_buff_addr = a[8:0];
				sd_buff_wr   = load;
				sd_buff_dout = host_img[{lba, a[8:0]}];
			end else
				sd_buff_wr = 1'b0;
			next_cycle();
		end
		sd_ack = 1'b0;  // Ends the sector
	endtask

	task automatic wait_idle();
		int n;
		n = 0;
		while (bk_busy && n < WAIT_CYC) begin
			next_cycle();
			n++;
		end
		if (bk_busy) begin
			errors++;
			$display("ERROR t=%0t bk_busy still high after the last sector", $time);
		end
		next_cycle();
	endtask

	task automatic test_early_save();
		sector_req_t none;
		int          n;
		none = '0;
		next_cycle();
		bk_save = 1'b1;
		for (n = 0; n < IDLE_CYC; n++) begin
			@(negedge clk_sys);
			check_req(none, sd_req);
			if (bk_busy) begin
				errors++;
				$display("ERROR t=%0t bk_busy high with no image mounted", $time);
			end
		end
		next_cycle();
		bk_save = 1'b0;
	endtask

	task automatic test_load();
		int a;
		int k;
		int r0;
		for (a = 0; a < 2048; a++)
			host_img[a] = 8'($urandom);
		r0 = resets;
		next_cycle();
		img_size_nz = 1'b1;
		img_mounted = 1'b1;
		next_cycle();
		img_mounted = 1'b0;
		for (k = 0; k < 4; k++)
			serve_sector(1'b1, 2'(k));
		wait_idle();
		if (resets - r0 != 1) begin
			errors++;
			$display("ERROR t=%0t console_reset pulsed %0d times on load", $time, resets - r0);
		end
		for (a = 0; a < 2048; a++) begin
			brm_model[a] = host_img[a];
			next_cycle();
			brm_port.addr = BRM_AW'(a);
			brm_port.we   = 1'b0;
			@(posedge clk_sys);
			@(negedge clk_sys);
			check_byte("brm_dout", host_img[a], brm_dout);
		end
	endtask

	task automatic test_save();
		int a;
		int k;
		int r0;
		for (a = 0; a < 2048; a++) begin
			next_cycle();
			brm_port.addr = BRM_AW'(a);
			brm_port.we   = 1'b1;
			brm_port.din  = 8'($urandom);
			brm_model[a]  = brm_port.din;
		end
		next_cycle();
		brm_port.we = 1'b0;
		r0 = resets;
		bk_save = 1'b1;
		for (k = 0; k < 4; k++)
			serve_sector(1'b0, 2'(k));
		wait_idle();
		bk_save = 1'b0;
		if (resets != r0) begin
			errors++;
			$display("ERROR t=%0t console_reset pulsed during a save", $time);
		end
	endtask

	task automatic report_test(input string name, input int err0);
		$display("test %-12s done, %0d errors", name, errors - err0);
	endtask

	// ==========================================================================
	// Main sequence
	// ==========================================================================
	initial begin
		int e0;
		void'($urandom(96));
		rst_n        = 1'b0;
		pad_bus      = '0;
		pads         = '0;
		opts         = '0;
		audio_src    = '0;
		audio_valid  = 1'b0;
		brm_port     = '0;
		sd_ack       = 1'b0;
		sd_buff_addr = '0;
		sd_buff_wr   = 1'b0;
		sd_buff_dout = '0;
		img_mounted  = 1'b0;
		img_size_nz  = 1'b0;
		bk_save      = 1'b0;
		repeat (2) @(posedge clk_sys);
		#2 rst_n = 1'b1;

		e0 = errors;
		test_pad_basic();
		report_test("pad_basic", e0);
		e0 = errors;
		test_pad_tap();
		report_test("pad_tap", e0);
		e0 = errors;
		test_audio();
		report_test("audio", e0);
		e0 = errors;
		test_early_save();  // Must run before any mount
		report_test("early_save", e0);
		e0 = errors;
		test_load();
		report_test("load", e0);
		e0 = errors;
		test_save();
		report_test("save", e0);

		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// ==== tgfx16_io.f ====
+incdir+bench
logic/tgfx16_pkg.sv
logic/pad_port.sv
logic/audio_mix.sv
logic/backup_ram.sv
logic/backup_sync.sv
logic/tgfx16_io_top.sv
bench/tgfx16_io_tb.sv

// ==== Bender.yml ====
package:
  name: tgfx16_io

sources:
  - logic/tgfx16_pkg.sv
  - logic/pad_port.sv
  - logic/audio_mix.sv
  - logic/backup_ram.sv
  - logic/backup_sync.sv
  - logic/tgfx16_io_top.sv
  - target: simulation
    include_dirs:
      - bench
    files:
      - bench/tgfx16_io_tb.sv
